// ==== sim.f ====
+incdir+.
decode_pkg.sv
instr_decoder.sv
reg_file.sv
scoreboard.sv
issue_regs.sv
decode_top.sv
tb_decode.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f sim.f --top-module tb_decode -o tb_decode_sim; then
    echo "Verilator compile failed"
    exit 1
fi

output=$(./obj_dir/tb_decode_sim)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "SIMULATION PASSED"; then
    exit 0
fi
exit 1

// ==== tb_decode_util.svh ====
`ifndef TB_DECODE_UTIL_SVH
`define TB_DECODE_UTIL_SVH

//////////////////////////////
// Random data

// Galois LFSR, one step per bit taken
function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++)
    begin
        value      = {value[30:0], lfsr_state[0]};
        lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? LFSR_TAPS : 32'h0);
    end
    return value;
endfunction

//////////////////////////////
// Compare tasks

task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
        $display("CHECK FAILED at %0t ns: %s expected %b, got %b", $time, name, exp, act);
        error_count++;
    end
endtask

task automatic check_id(input string name, input rob_id_t exp, input rob_id_t act);
    if (act !== exp)
    begin
        $display("CHECK FAILED at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
        error_count++;
    end
endtask

task automatic check_alu(input string name, input alu_req_t exp, input alu_req_t act);
    alu_req_t seen;
    seen = act;
    // A used source's ticket only matters while it is blocked
    if (reads_src1(exp.opcode) && !exp.src1.blocked)
    begin
        seen.src1.ticket = exp.src1.ticket;
    end
    if (reads_src2(exp.opcode) && !exp.src2.blocked)
    begin
        seen.src2.ticket = exp.src2.ticket;
    end
    if (seen !== exp)
    begin
        $display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        error_count++;
    end
endtask

task automatic check_mul(input string name, input mul_req_t exp, input mul_req_t act);
    mul_req_t seen;
    seen = act;
    if (!exp.src1.blocked)
    begin
        seen.src1.ticket = exp.src1.ticket;
    end
    if (!exp.src2.blocked)
    begin
        seen.src2.ticket = exp.src2.ticket;
    end
    if (seen !== exp)
    begin
        $display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        error_count++;
    end
endtask

//////////////////////////////
// Instruction words

function automatic logic [31:0] r_word(input opcode_t op, input reg_addr_t rd,
                                       input reg_addr_t ra, input reg_addr_t rb);
    return {op, rd, ra, rb, 10'h000};
endfunction

function automatic logic [31:0] i_word(input opcode_t op, input reg_addr_t rd,
                                       input reg_addr_t ra, input logic [14:0] imm);
    return {op, rd, ra, imm};
endfunction

// Branch offset is split, high part where rd would be
function automatic logic [31:0] b_word(input opcode_t op, input reg_addr_t ra,
                                       input reg_addr_t rb, input logic [14:0] off);
    return {op, off[14:10], ra, rb, off[9:0]};
endfunction

//////////////////////////////
// Expected requests

function automatic logic reads_src1(input opcode_t op);
    return op inside {OP_ADD, OP_SUB, OP_MUL, OP_ADDI, OP_LDW, OP_STW, OP_BEQ};
endfunction

function automatic logic reads_src2(input opcode_t op);
    return op inside {OP_ADD, OP_SUB, OP_MUL, OP_STW, OP_BEQ};
endfunction

function automatic logic [OFFSET_W-1:0] expected_offset(input logic [31:0] word);
    case (word[31:25])
        OP_ADDI, OP_LDW, OP_STW: return OFFSET_W'(word[14:0]);
        OP_BEQ:                  return OFFSET_W'({word[24:20], word[9:0]});
        default:                 return '0;
    endcase
endfunction

function automatic src_op_t make_src(input reg_addr_t addr, input logic used,
                                     input logic blocked, input rob_id_t ticket);
    src_op_t s;
    s.addr    = addr;
    s.data    = model_regs[addr];
    s.ticket  = used ? ticket : '0;
    s.blocked = used && blocked;
    return s;
endfunction

function automatic alu_req_t expect_alu(input logic [31:0] word, input logic [PC_W-1:0] pc,
                                        input logic b1, input rob_id_t t1,
                                        input logic b2, input rob_id_t t2);
    alu_req_t  e;
    opcode_t   op;
    reg_addr_t a2;
    op = word[31:25];
    // Stores take their data from the rd field
    a2 = (op == OP_STW) ? word[24:20] : word[14:10];
    e.opcode  = op;
    e.rd      = word[24:20];
    e.src1    = make_src(word[19:15], reads_src1(op), b1, t1);
    e.src2    = make_src(a2, reads_src2(op), b2, t2);
    e.offset  = expected_offset(word);
    e.pc      = pc;
    e.rob_id  = last_id;
    e.illegal = !(reads_src1(op) || op == OP_NOP);
    return e;
endfunction

function automatic mul_req_t expect_mul(input logic [31:0] word, input logic [PC_W-1:0] pc,
                                        input logic b1, input rob_id_t t1,
                                        input logic b2, input rob_id_t t2);
    mul_req_t e;
    e.rd     = word[24:20];
    e.src1   = make_src(word[19:15], 1'b1, b1, t1);
    e.src2   = make_src(word[14:10], 1'b1, b2, t2);
    e.pc     = pc;
    e.rob_id = last_id;
    return e;
endfunction

`endif

// ==== tb_decode.sv ====
`timescale 1ns/10ps

module tb_decode;
    import decode_pkg::*;

    localparam int          CLK_PERIOD = 100;
    // Reset, register preload and tests take about 80 cycles
    localparam int          MAX_CYCLES = 400;
    localparam logic [31:0] LFSR_TAPS  = 32'h80200003;

    logic      clock;
    logic      rst_n;
    fetch_t    fetch;
    rf_write_t writeback;
    logic      stall;
    logic      flush_decode;
    logic      flush_rob;
    logic      alu_valid;
    logic      mul_valid;
    alu_req_t  alu_req;
    mul_req_t  mul_req;

    logic [31:0] lfsr_state;
    data_t       model_regs [NUM_REGS];
    rob_id_t     next_id;
    rob_id_t     last_id;
    int          error_count;
    int          errors_at_start;
    int          tests_passed;
    int          tests_failed;
    int          cycle_count;

    `include "tb_decode_util.svh"

    decode_top decode_top_inst
    (
        .clock        ( clock        ),
        .rst_n        ( rst_n        ),
        .fetch        ( fetch        ),
        .writeback    ( writeback    ),
        .stall        ( stall        ),
        .flush_decode ( flush_decode ),
        .flush_rob    ( flush_rob    ),
        .alu_valid    ( alu_valid    ),
        .mul_valid    ( mul_valid    ),
        .alu_req      ( alu_req      ),
        .mul_req      ( mul_req      )
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    always @(posedge clock)
    begin
        cycle_count <= cycle_count + 1;
    end

    //////////////////////////////
    // Drive helpers, all called on a falling edge

    task automatic advance_id();
        last_id = next_id;
        next_id = rob_id_t'(next_id + 1);
    endtask

    task automatic send(input logic [31:0] word, input logic [PC_W-1:0] pc);
        fetch.valid = 1'b1;
        fetch.instr = instr_u'(word);
        fetch.pc    = pc;
        @(negedge clock);
        fetch.valid  = 1'b0;
        writeback.en = 1'b0;
        advance_id();
    endtask

    task automatic drive_writeback(input reg_addr_t addr, input data_t data, input rob_id_t id);
        writeback.en     = 1'b1;
        writeback.addr   = addr;
        writeback.data   = data;
        writeback.rob_id = id;
        model_regs[addr] = data;
    endtask

    task automatic write_reg(input reg_addr_t addr, input data_t data, input rob_id_t id);
        drive_writeback(addr, data, id);
        @(negedge clock);
        writeback.en = 1'b0;
    endtask

    task automatic preload_regs();
        for (int i = 0; i < NUM_REGS; i++)
        begin
            write_reg(reg_addr_t'(i), data_t'(random_bits(32)), '0);
        end
    endtask

    task automatic flush_rob_pulse();
        flush_rob = 1'b1;
        @(negedge clock);
        flush_rob = 1'b0;
        next_id   = '0;
    endtask

    task automatic settle();
        #(CLK_PERIOD / 4);
    endtask

    task automatic expect_on_alu(input alu_req_t exp);
        check_bit("alu_valid", 1'b1, alu_valid);
        check_bit("mul_valid", 1'b0, mul_valid);
        check_alu("alu_req", exp, alu_req);
    endtask

    task automatic expect_on_mul(input mul_req_t exp);
        check_bit("mul_valid", 1'b1, mul_valid);
        check_bit("alu_valid", 1'b0, alu_valid);
        check_mul("mul_req", exp, mul_req);
    endtask

    // Issue one instruction whose sources wait on nothing
    task automatic alu_unblocked(input logic [31:0] word, input logic [PC_W-1:0] pc);
        send(word, pc);
        expect_on_alu(expect_alu(word, pc, 1'b0, '0, 1'b0, '0));
    endtask

    task automatic open_test();
        errors_at_start = error_count;
    endtask

    task automatic close_test(input string name);
        if (error_count == errors_at_start)
        begin
            tests_passed++;
            $display("Test %s passed", name);
        end
        else
        begin
            tests_failed++;
            $display("Test %s failed with %0d errors", name, error_count - errors_at_start);
        end
    endtask

    //////////////////////////////
    // Directed tests

    task automatic reset_id_test();
        logic [31:0] word;
        open_test();
        check_bit("alu_valid", 1'b0, alu_valid);
        check_bit("mul_valid", 1'b0, mul_valid);
        // Writebacks alone consume no ROB id
        preload_regs();
        for (int i = 0; i < 3; i++)
        begin
            word = r_word(OP_NOP, reg_addr_t'(i + 1), reg_addr_t'(i + 2), reg_addr_t'(i + 3));
            alu_unblocked(word, 32'h0000_1000 + 32'(4 * i));
            check_id("alu_req.rob_id", rob_id_t'(i), alu_req.rob_id);
        end
        close_test("reset and ROB ids");
    endtask

    task automatic steering_test();
        logic [31:0] word;
        open_test();
        flush_rob_pulse();
        alu_unblocked(r_word(OP_ADD, 5'd1, 5'd2, 5'd3), 32'h0000_2000);
        alu_unblocked(i_word(OP_ADDI, 5'd4, 5'd5, 15'h1234), 32'h0000_2004);
        alu_unblocked(i_word(OP_LDW, 5'd6, 5'd7, 15'h7abc), 32'h0000_2008);
        alu_unblocked(i_word(OP_STW, 5'd8, 5'd9, 15'h0155), 32'h0000_200c);
        alu_unblocked(b_word(OP_BEQ, 5'd10, 5'd11, 15'h2b3c), 32'h0000_2010);
        alu_unblocked(r_word(OP_NOP, 5'd0, 5'd0, 5'd0), 32'h0000_2014);
        word = r_word(OP_MUL, 5'd12, 5'd13, 5'd14);
        send(word, 32'h0000_2018);
        expect_on_mul(expect_mul(word, 32'h0000_2018, 1'b0, '0, 1'b0, '0));
        close_test("steering and decode");
    endtask

    task automatic reg_read_test();
        open_test();
        flush_rob_pulse();
        write_reg(5'd20, data_t'(random_bits(32)), '0);
        alu_unblocked(r_word(OP_ADD, 5'd21, 5'd20, 5'd22), 32'h0000_3000);
        // Same-cycle write must be forwarded
        drive_writeback(5'd24, data_t'(random_bits(32)), '0);
        alu_unblocked(r_word(OP_ADD, 5'd23, 5'd24, 5'd20), 32'h0000_3004);
        alu_unblocked(i_word(OP_STW, 5'd20, 5'd26, 15'h0040), 32'h0000_3008);
        close_test("register read");
    endtask

    task automatic scoreboard_test();
        logic [31:0] word;
        rob_id_t     producer;
        open_test();
        flush_rob_pulse();
        alu_unblocked(r_word(OP_ADD, 5'd5, 5'd1, 5'd2), 32'h0000_4000);
        producer = last_id;
        word = r_word(OP_ADD, 5'd6, 5'd5, 5'd3);
        send(word, 32'h0000_4004);
        expect_on_alu(expect_alu(word, 32'h0000_4004, 1'b1, producer, 1'b0, '0));
        // Wrong id leaves the register waiting
        drive_writeback(5'd5, data_t'(random_bits(32)), rob_id_t'(producer + 7));
        word = r_word(OP_ADD, 5'd7, 5'd3, 5'd5);
        send(word, 32'h0000_4008);
        expect_on_alu(expect_alu(word, 32'h0000_4008, 1'b0, '0, 1'b1, producer));
        // The mark outlives the wrong-id writeback
        word = r_word(OP_ADD, 5'd13, 5'd5, 5'd3);
        send(word, 32'h0000_401c);
        expect_on_alu(expect_alu(word, 32'h0000_401c, 1'b1, producer, 1'b0, '0));
        // Matching id wakes the reader in the same cycle
        drive_writeback(5'd5, data_t'(random_bits(32)), producer);
        alu_unblocked(r_word(OP_ADD, 5'd8, 5'd5, 5'd4), 32'h0000_400c);
        alu_unblocked(r_word(OP_ADD, 5'd9, 5'd5, 5'd5), 32'h0000_4010);
        alu_unblocked(r_word(OP_ADD, 5'd10, 5'd1, 5'd2), 32'h0000_4014);
        flush_rob_pulse();
        alu_unblocked(r_word(OP_ADD, 5'd11, 5'd10, 5'd6), 32'h0000_4018);
        check_id("alu_req.rob_id", '0, alu_req.rob_id);
        close_test("scoreboard");
    endtask

    task automatic stall_flush_test();
        logic [31:0] word_a;
        logic [31:0] word_b;
        logic [31:0] word_d;
        alu_req_t    held;
        open_test();
        flush_rob_pulse();
        word_a = r_word(OP_ADD, 5'd12, 5'd1, 5'd2);
        send(word_a, 32'h0000_5000);
        held = expect_alu(word_a, 32'h0000_5000, 1'b0, '0, 1'b0, '0);
        expect_on_alu(held);
        // Fetch holds the MUL while the stage is stalled
        word_b      = r_word(OP_MUL, 5'd13, 5'd3, 5'd4);
        fetch.valid = 1'b1;
        fetch.instr = instr_u'(word_b);
        fetch.pc    = 32'h0000_5004;
        stall       = 1'b1;
        repeat (2)
        begin
            @(negedge clock);
            check_bit("alu_valid", 1'b0, alu_valid);
            check_bit("mul_valid", 1'b0, mul_valid);
        end
        stall = 1'b0;
        settle();
        check_bit("alu_valid", 1'b1, alu_valid);
        check_alu("alu_req", held, alu_req);
        @(negedge clock);
        fetch.valid = 1'b0;
        advance_id();
        expect_on_mul(expect_mul(word_b, 32'h0000_5004, 1'b0, '0, 1'b0, '0));
        check_id("mul_req.rob_id", rob_id_t'(held.rob_id + 1), mul_req.rob_id);
        // Pending ADDI is hidden while flush_decode is high
        word_d = i_word(OP_ADDI, 5'd14, 5'd5, 15'h0321);
        alu_unblocked(word_d, 32'h0000_5008);
        flush_decode = 1'b1;
        settle();
        check_bit("alu_valid", 1'b0, alu_valid);
        @(negedge clock);
        flush_decode = 1'b0;
        // A held ADDI flushed during stall does not come back
        alu_unblocked(word_d, 32'h0000_500c);
        stall        = 1'b1;
        flush_decode = 1'b1;
        @(negedge clock);
        stall        = 1'b0;
        flush_decode = 1'b0;
        settle();
        check_bit("alu_valid", 1'b0, alu_valid);
        check_bit("mul_valid", 1'b0, mul_valid);
        @(negedge clock);
        close_test("stall and flush");
    endtask

    task automatic illegal_test();
        open_test();
        flush_rob_pulse();
        alu_unblocked({7'h55, 5'd15, 5'd16, 5'd17, 10'h2a5}, 32'h0000_6000);
        check_bit("alu_req.illegal", 1'b1, alu_req.illegal);
        check_id("alu_req.rob_id", '0, alu_req.rob_id);
        // rd of the illegal word stays free
        alu_unblocked(r_word(OP_ADD, 5'd18, 5'd15, 5'd15), 32'h0000_6004);
        check_id("alu_req.rob_id", 6'd1, alu_req.rob_id);
        close_test("illegal opcode");
    endtask

    //////////////////////////////
    // Run

    initial
    begin
        clock           = 1'b0;
        rst_n           = 1'b0;
        fetch           = '0;
        writeback       = '0;
        stall           = 1'b0;
        flush_decode    = 1'b0;
        flush_rob       = 1'b0;
        lfsr_state      = 32'hd449f25b;
        next_id         = '0;
        last_id         = '0;
        error_count     = 0;
        errors_at_start = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        cycle_count     = 0;
        repeat (2) @(negedge clock);
        rst_n = 1'b1;
        reset_id_test();
        steering_test();
        reg_read_test();
        scoreboard_test();
        stall_flush_test();
        illegal_test();
        $display("Tests passed: %0d, tests failed: %0d, check errors: %0d",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0)
        begin
            $display("SIMULATION PASSED");
        end
        else
        begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial
    begin
        wait (cycle_count >= MAX_CYCLES);
        $display("Timeout: tests did not finish within %0d cycles", MAX_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== decode_top.sv ====
`timescale 1ns/10ps

module decode_top
(
    input  logic                  clock,
    input  logic                  rst_n,
    input  decode_pkg::fetch_t    fetch,
    input  decode_pkg::rf_write_t writeback,
    input  logic                  stall,
    input  logic                  flush_decode,
    input  logic                  flush_rob,
    output logic                  alu_valid,
    output logic                  mul_valid,
    output decode_pkg::alu_req_t  alu_req,
    output decode_pkg::mul_req_t  mul_req
);
    import decode_pkg::*;

    instr_class_t        cls;
    opcode_t             opcode;
    reg_addr_t           rd;
    reg_addr_t           ra;
    reg_addr_t           src2_addr;
    logic [OFFSET_W-1:0] offset;
    logic                illegal;
    data_t               src1_data;
    data_t               src2_data;
    rob_id_t             src1_ticket;
    rob_id_t             src2_ticket;
    logic                src1_blocked;
    logic                src2_blocked;
    rob_id_t             rob_id;
    logic                accept;
    src_op_t             src1;
    src_op_t             src2;
    alu_req_t            alu_next;
    mul_req_t            mul_next;

    // One instruction per cycle unless held or flushed
    assign accept = fetch.valid && !stall && !flush_decode;

    instr_decoder instr_decoder_inst
    (
        .instr     ( fetch.instr ),
        .cls       ( cls         ),
        .opcode    ( opcode      ),
        .rd        ( rd          ),
        .ra        ( ra          ),
        .rb        (             ),
        .src2_addr ( src2_addr   ),
        .offset    ( offset      ),
        .illegal   ( illegal     )
    );

    reg_file reg_file_inst
    (
        .clock     ( clock     ),
        .rst_n     ( rst_n     ),
        .rd_addr1  ( ra        ),
        .rd_addr2  ( src2_addr ),
        .rd_data1  ( src1_data ),
        .rd_data2  ( src2_data ),
        .wr        ( writeback )
    );

    scoreboard scoreboard_inst
    (
        .clock        ( clock        ),
        .rst_n        ( rst_n        ),
        .flush_rob    ( flush_rob    ),
        .accept       ( accept       ),
        .cls          ( cls          ),
        .rd           ( rd           ),
        .ra           ( ra           ),
        .src2_addr    ( src2_addr    ),
        .wr           ( writeback    ),
        .src1_ticket  ( src1_ticket  ),
        .src2_ticket  ( src2_ticket  ),
        .src1_blocked ( src1_blocked ),
        .src2_blocked ( src2_blocked ),
        .rob_id       ( rob_id       )
    );

    //////////////////////////////
    // Request assembly

    always_comb
    begin
        src1 = '{addr: ra, data: src1_data, ticket: src1_ticket, blocked: src1_blocked};
        src2 = '{addr: src2_addr, data: src2_data, ticket: src2_ticket, blocked: src2_blocked};

        alu_next.opcode  = opcode;
        alu_next.rd      = rd;
        alu_next.src1    = src1;
        alu_next.src2    = src2;
        alu_next.offset  = offset;
        alu_next.pc      = fetch.pc;
        alu_next.rob_id  = rob_id;
        alu_next.illegal = illegal;

        mul_next.rd      = rd;
        mul_next.src1    = src1;
        mul_next.src2    = src2;
        mul_next.pc      = fetch.pc;
        mul_next.rob_id  = rob_id;
    end

    issue_regs issue_regs_inst
    (
        .clock        ( clock        ),
        .rst_n        ( rst_n        ),
        .stall        ( stall        ),
        .flush_decode ( flush_decode ),
        .accept       ( accept       ),
        .is_mul       ( cls.mul      ),
        .alu_next     ( alu_next     ),
        .mul_next     ( mul_next     ),
        .alu_valid    ( alu_valid    ),
        .mul_valid    ( mul_valid    ),
        .alu_req      ( alu_req      ),
        .mul_req      ( mul_req      )
    );

endmodule

// ==== issue_regs.sv ====
`timescale 1ns/10ps

module issue_regs
(
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 stall,
    input  logic                 flush_decode,
    input  logic                 accept,
    input  logic                 is_mul,
    input  decode_pkg::alu_req_t alu_next,
    input  decode_pkg::mul_req_t mul_next,
    output logic                 alu_valid,
    output logic                 mul_valid,
    output decode_pkg::alu_req_t alu_req,
    output decode_pkg::mul_req_t mul_req
);
    import decode_pkg::*;

    logic     alu_valid_q;
    logic     mul_valid_q;
    alu_req_t alu_req_q;
    mul_req_t mul_req_q;
    logic     hold;
    logic     load_alu;
    logic     load_mul;

    assign load_alu = accept && !is_mul;
    assign load_mul = accept && is_mul;

    //////////////////////////////
    // Valid bits

    // Stall freezes the valid bits, flush drops whatever is pending
    always_ff @(posedge clock)
    begin
        if (!rst_n || flush_decode)
        begin
            alu_valid_q <= 1'b0;
            mul_valid_q <= 1'b0;
        end
        else if (!stall)
        begin
            alu_valid_q <= load_alu;
            mul_valid_q <= load_mul;
        end
    end

    //////////////////////////////
    // Request payload

    // Loaded only on acceptance, so a held item keeps its contents
    always_ff @(posedge clock)
    begin
        if (load_alu)
        begin
            alu_req_q <= alu_next;
        end
        if (load_mul)
        begin
            mul_req_q <= mul_next;
        end
    end

    //////////////////////////////
    // Outputs

    assign hold = stall || flush_decode;

    assign alu_valid = alu_valid_q && !hold;
    assign mul_valid = mul_valid_q && !hold;
    assign alu_req   = alu_req_q;
    assign mul_req   = mul_req_q;

    // Each accepted instruction goes to exactly one port
    assert property (@(posedge clock) disable iff (!rst_n)
        !(alu_valid && mul_valid))
    else $error("issue_regs: ALU and MUL requests valid together");

endmodule

// ==== scoreboard.sv ====
`timescale 1ns/10ps

module scoreboard
(
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     flush_rob,
    input  logic                     accept,
    input  decode_pkg::instr_class_t cls,
    input  decode_pkg::reg_addr_t    rd,
    input  decode_pkg::reg_addr_t    ra,
    input  decode_pkg::reg_addr_t    src2_addr,
    input  decode_pkg::rf_write_t    wr,
    output decode_pkg::rob_id_t      src1_ticket,
    output decode_pkg::rob_id_t      src2_ticket,
    output logic                     src1_blocked,
    output logic                     src2_blocked,
    output decode_pkg::rob_id_t      rob_id
);
    import decode_pkg::*;

    // Per register: waiting flag and the id of the producer it waits on
    logic [NUM_REGS-1:0] blocked_q;
    rob_id_t             owner_q [NUM_REGS];
    rob_id_t             tail_q;

    logic uses_src1;
    logic uses_src2;
    logic writes_rd;
    logic src1_woken;
    logic src2_woken;
    logic wr_match;

    //////////////////////////////
    // Source lookup

    assign uses_src1 = cls.r_type | cls.mul | cls.imm | cls.load | cls.store | cls.branch;
    assign uses_src2 = cls.r_type | cls.mul | cls.store | cls.branch;

    // Illegal opcodes decode to no class, so they never mark rd
    assign writes_rd = cls.r_type | cls.mul | cls.imm | cls.load;

    // A writeback carrying the stored id releases the source this cycle
    assign src1_woken = wr.en && (wr.rob_id == owner_q[ra]);
    assign src2_woken = wr.en && (wr.rob_id == owner_q[src2_addr]);

    assign src1_blocked = uses_src1 && blocked_q[ra] && !src1_woken;
    assign src2_blocked = uses_src2 && blocked_q[src2_addr] && !src2_woken;

    assign src1_ticket = uses_src1 ? owner_q[ra] : '0;
    assign src2_ticket = uses_src2 ? owner_q[src2_addr] : '0;

    assign rob_id = tail_q;

    //////////////////////////////
    // Marks and tail

    assign wr_match = wr.en && (owner_q[wr.addr] == wr.rob_id);

    always_ff @(posedge clock)
    begin
        if (!rst_n || flush_rob)
        begin
            blocked_q <= '0;
            tail_q    <= '0;
        end
        else
        begin
            if (accept)
            begin
                tail_q <= tail_q + 1'b1;
            end
            if (wr_match)
            begin
                blocked_q[wr.addr] <= 1'b0;
            end
            // Comes last so a new mark on the same register wins
            if (accept && writes_rd)
            begin
                blocked_q[rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock)
    begin
        if (accept && writes_rd)
        begin
            owner_q[rd] <= tail_q;
        end
    end

    // An accept that coincides with the start of a ROB flush must still carry a class
    assert property (@(posedge clock) disable iff (!rst_n)
        (flush_rob && !$past(flush_rob) && accept) |-> !$isunknown(cls))
    else $error("scoreboard: accept with unknown class at ROB flush");

endmodule

// ==== reg_file.sv ====
`timescale 1ns/10ps

module reg_file
(
    input  logic                  clock,
    input  logic                  rst_n,
    input  decode_pkg::reg_addr_t rd_addr1,
    input  decode_pkg::reg_addr_t rd_addr2,
    output decode_pkg::data_t     rd_data1,
    output decode_pkg::data_t     rd_data2,
    input  decode_pkg::rf_write_t wr
);
    import decode_pkg::*;

    data_t regs [NUM_REGS];
    logic  fwd1;
    logic  fwd2;

    //////////////////////////////
    // Write port

    // Writes arriving while in reset are dropped
    always_ff @(posedge clock)
    begin
        if (rst_n && wr.en)
        begin
            regs[wr.addr] <= wr.data;
        end
    end

    //////////////////////////////
    // Read ports

    // Bypass a write to the same address in this cycle
    assign fwd1 = wr.en && (wr.addr == rd_addr1);
    assign fwd2 = wr.en && (wr.addr == rd_addr2);

    assign rd_data1 = fwd1 ? wr.data : regs[rd_addr1];
    assign rd_data2 = fwd2 ? wr.data : regs[rd_addr2];

endmodule

// ==== instr_decoder.sv ====
`timescale 1ns/10ps

module instr_decoder
(
    input  decode_pkg::instr_u              instr,
    output decode_pkg::instr_class_t        cls,
    output decode_pkg::opcode_t             opcode,
    output decode_pkg::reg_addr_t           rd,
    output decode_pkg::reg_addr_t           ra,
    output decode_pkg::reg_addr_t           rb,
    output decode_pkg::reg_addr_t           src2_addr,
    output logic [decode_pkg::OFFSET_W-1:0] offset,
    output logic                            illegal
);
    import decode_pkg::*;

    logic [IMM_W-1:0] imm_ri;
    logic [IMM_W-1:0] imm_b;

    // Register fields sit at the same place in both views
    assign opcode = instr.r.opcode;
    assign rd     = instr.r.rd;
    assign ra     = instr.r.ra;
    assign rb     = instr.r.rb;

    // Immediate candidates from the two views of the word
    assign imm_ri = {instr.r.rb, instr.r.unused};
    assign imm_b  = {instr.b.off_hi, instr.b.off_lo};

    //////////////////////////////
    // Class and offset decode

    always_comb
    begin
        cls       = '0;
        offset    = '0;
        illegal   = 1'b0;
        src2_addr = instr.r.rb;

        case (instr.r.opcode)
            OP_ADD, OP_SUB:
                cls.r_type = 1'b1;
            OP_MUL:
                cls.mul = 1'b1;
            OP_ADDI:
            begin
                cls.imm = 1'b1;
                offset  = OFFSET_W'(imm_ri);
            end
            OP_LDW:
            begin
                cls.load = 1'b1;
                offset   = OFFSET_W'(imm_ri);
            end
            OP_STW:
            begin
                // Store data comes from the rd field
                cls.store = 1'b1;
                offset    = OFFSET_W'(imm_ri);
                src2_addr = instr.r.rd;
            end
            OP_BEQ:
            begin
                cls.branch = 1'b1;
                offset     = OFFSET_W'(imm_b);
            end
            OP_NOP:
                cls.nop = 1'b1;
            default:
                illegal = 1'b1;
        endcase
    end

    // Scoreboard and steering rely on a single class per instruction
    always_comb
    begin
        assert ($onehot0(cls))
        else $error("instr_decoder: more than one class bit set");
    end

endmodule

// ==== decode_pkg.sv ====
package decode_pkg;

    //////////////////////////////
    // Widths

    localparam int INSTR_W    = 32;
    localparam int DATA_W     = 32;
    localparam int PC_W       = 32;
    localparam int NUM_REGS   = 32;
    localparam int REG_ADDR_W = 5;
    localparam int ROB_ID_W   = 6;
    localparam int OFFSET_W   = 32;
    localparam int OPCODE_W   = 7;

    // Immediate taken from the low part of the word
    localparam int IMM_W      = 15;

    // Bits left below opcode and the three register fields
    localparam int FILL_W     = INSTR_W - OPCODE_W - 3 * REG_ADDR_W;

    typedef logic [OPCODE_W-1:0]   opcode_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [ROB_ID_W-1:0]   rob_id_t;
    typedef logic [DATA_W-1:0]     data_t;

    //////////////////////////////
    // Opcodes

    localparam opcode_t OP_ADD  = 7'h00;
    localparam opcode_t OP_SUB  = 7'h01;
    localparam opcode_t OP_MUL  = 7'h02;
    localparam opcode_t OP_ADDI = 7'h10;
    localparam opcode_t OP_LDW  = 7'h11;
    localparam opcode_t OP_STW  = 7'h13;
    localparam opcode_t OP_BEQ  = 7'h30;
    localparam opcode_t OP_NOP  = 7'h7F;

    //////////////////////////////
    // Instruction formats

    // R/I format, also used by loads and stores
    typedef struct packed {
        opcode_t             opcode;
        reg_addr_t           rd;
        reg_addr_t           ra;
        reg_addr_t           rb;
        logic [FILL_W-1:0]   unused;
    } instr_r_t;

    // Branch format, offset split around the source fields
    typedef struct packed {
        opcode_t             opcode;
        logic [REG_ADDR_W-1:0] off_hi;
        reg_addr_t           ra;
        reg_addr_t           rb;
        logic [FILL_W-1:0]   off_lo;
    } instr_b_t;

    typedef union packed {
        instr_r_t r;
        instr_b_t b;
    } instr_u;

    //////////////////////////////
    // Port bundles

    typedef struct packed {
        logic              valid;
        instr_u            instr;
        logic [PC_W-1:0]   pc;
    } fetch_t;

    typedef struct packed {
        logic      en;
        reg_addr_t addr;
        data_t     data;
        rob_id_t   rob_id;
    } rf_write_t;

    typedef struct packed {
        reg_addr_t addr;
        data_t     data;
        rob_id_t   ticket;
        logic      blocked;
    } src_op_t;

    typedef struct packed {
        opcode_t               opcode;
        reg_addr_t             rd;
        src_op_t               src1;
        src_op_t               src2;
        logic [OFFSET_W-1:0]   offset;
        logic [PC_W-1:0]       pc;
        rob_id_t               rob_id;
        logic                  illegal;
    } alu_req_t;

    typedef struct packed {
        reg_addr_t         rd;
        src_op_t           src1;
        src_op_t           src2;
        logic [PC_W-1:0]   pc;
        rob_id_t           rob_id;
    } mul_req_t;

    // One-hot instruction class, all zero for an illegal opcode
    typedef struct packed {
        logic r_type;
        logic mul;
        logic imm;
        logic load;
        logic store;
        logic branch;
        logic nop;
    } instr_class_t;

endpackage
